//--- Makefile
TOP := tb_pe_array

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || (echo "Simulation did not complete"; exit 1)

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- common/pe_ifs.sv
// Buses between a PE lane and its add/subtract and multiply units
`timescale 1ns/1ps

interface mod_addsub_if #(
    parameter int W = 24
);
    logic         dsa_mode;
    logic [W-1:0] add_a;
    logic [W-1:0] add_b;
    logic [W-1:0] sub_a;
    logic [W-1:0] sub_b;
    logic [W-1:0] sum;
    logic [W-1:0] diff;

    modport lane (output dsa_mode, add_a, add_b, sub_a, sub_b, input sum, diff);
    modport unit (input dsa_mode, add_a, add_b, sub_a, sub_b, output sum, diff);
endinterface

interface mod_mul_if #(
    parameter int W = 24
);
    logic         dsa_mode;
    logic [W-1:0] mul_a;
    logic [W-1:0] mul_b;
    logic [W-1:0] prod;   // a*b mod q, four cycles later

    modport lane (output dsa_mode, mul_a, mul_b, input prod);
    modport unit (input dsa_mode, mul_a, mul_b, output prod);
endinterface

//--- common/pe_pkg.sv
// Shared types, widths, moduli and Barrett constants; referenced as pe_pkg::name everywhere
package pe_pkg;

    typedef enum logic [2:0] {
        MADD   = 3'd0,
        MSUB   = 3'd1,
        MMUL   = 3'd2,
        NTT    = 3'd3,   // Cooley-Tukey butterfly
        INTT   = 3'd4,   // Gentleman-Sande butterfly
        BYPASS = 3'd5
    } pe_instr_t;

    typedef enum logic [2:0] {
        KEM_512  = 3'd0,
        KEM_768  = 3'd1,
        KEM_1024 = 3'd2,
        DSA_44   = 3'd3,
        DSA_65   = 3'd4,
        DSA_87   = 3'd5
    } pe_alg_t;

    // Datapath shape
    localparam int WIDTH     = 24;
    localparam int NUM_LANES = 4;
    localparam int IN_NUM    = 3;
    localparam int OUT_NUM   = 2;

    // Moduli
    localparam logic [WIDTH-1:0] Q_KEM = 24'd3329;
    localparam logic [WIDTH-1:0] Q_DSA = 24'd8380417;

    // Barrett factors, floor(2^K / q)
    localparam logic [2*WIDTH-1:0] MU_KEM = 48'd5039;
    localparam logic [2*WIDTH-1:0] MU_DSA = 48'd8396807;

    localparam int BARRETT_K_KEM = 24;
    localparam int BARRETT_K_DSA = 46;

    // Cycles from operands to result
    localparam int LAT_ADDSUB = 1;
    localparam int LAT_MUL    = 4;
    localparam int LAT_BFLY   = 5;   // multiply plus add/subtract

endpackage

//--- mod_mul/mod_mul.sv
// Pipelined modular multiplier of one lane: product register, Barrett reducer, output register
`timescale 1ns/1ps

module mod_mul (
    input logic     clk,
    input logic     rst,
    mod_mul_if.unit bus
);

    logic [2*pe_pkg::WIDTH-1:0] product_r;
    logic                       mode_r;
    logic [pe_pkg::WIDTH-1:0]   residue;

    // Stage 1, full double-width product
    always_ff @(posedge clk) begin
        if (rst) begin
            product_r <= '0;
            mode_r    <= 1'b0;
        end else begin
            product_r <= (2*pe_pkg::WIDTH)'(bus.mul_a) * (2*pe_pkg::WIDTH)'(bus.mul_b);
            mode_r    <= bus.dsa_mode;   // Follows the product into the reducer
        end
    end

    // Stages 2 and 3
    mod_reduce i_reduce (
        .clk      (clk),
        .rst      (rst),
        .dsa_mode (mode_r),
        .product  (product_r),
        .residue  (residue)
    );

    // Stage 4
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.prod <= '0;
        end else begin
            bus.prod <= residue;
        end
    end

endmodule

//--- mod_mul/mod_reduce.sv
// Two-stage Barrett reduction of a double-width product modulo the KEM or DSA prime
`timescale 1ns/1ps

module mod_reduce (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dsa_mode,   // 0 KEM, 1 DSA
    input  logic [2*pe_pkg::WIDTH-1:0] product,
    output logic [pe_pkg::WIDTH-1:0]   residue
);

    logic [2*pe_pkg::WIDTH-1:0] mu;
    logic [3*pe_pkg::WIDTH-1:0] est;
    logic [pe_pkg::WIDTH-1:0]   quot;

    logic [2*pe_pkg::WIDTH-1:0] product_r;
    logic [pe_pkg::WIDTH-1:0]   quot_r;
    logic                       mode_r;

    logic [pe_pkg::WIDTH-1:0]   q;
    logic [pe_pkg::WIDTH+1:0]   rem;
    logic [pe_pkg::WIDTH+1:0]   rem1;
    logic [pe_pkg::WIDTH+1:0]   rem2;

    // Quotient estimate, short of the true one by at most two
    assign mu   = dsa_mode ? pe_pkg::MU_DSA : pe_pkg::MU_KEM;
    assign est  = (3*pe_pkg::WIDTH)'(product) * (3*pe_pkg::WIDTH)'(mu);
    assign quot = dsa_mode ? est[pe_pkg::BARRETT_K_DSA +: pe_pkg::WIDTH]
                           : est[pe_pkg::BARRETT_K_KEM +: pe_pkg::WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            product_r <= '0;
            quot_r    <= '0;
            mode_r    <= 1'b0;
        end else begin
            product_r <= product;
            quot_r    <= quot;
            mode_r    <= dsa_mode;
        end
    end

    assign q = mode_r ? pe_pkg::Q_DSA : pe_pkg::Q_KEM;

    // Remainder lies below 3q, so the low bits are exact
    assign rem = product_r[pe_pkg::WIDTH+1:0]
               - (pe_pkg::WIDTH+2)'((pe_pkg::WIDTH+2)'(quot_r) * (pe_pkg::WIDTH+2)'(q));

    always_comb begin
        rem1 = rem;
        if (rem >= {2'b00, q}) begin
            rem1 = rem - {2'b00, q};
        end
        rem2 = rem1;
        if (rem1 >= {2'b00, q}) begin
            rem2 = rem1 - {2'b00, q};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            residue <= '0;
        end else begin
            residue <= rem2[pe_pkg::WIDTH-1:0];
        end
    end

endmodule

//--- project.f
common/pe_pkg.sv
common/pe_ifs.sv
source/mod_addsub.sv
mod_mul/mod_reduce.sv
mod_mul/mod_mul.sv
source/pe_lane.sv
source/pe_array.sv
sim/tb_clock.sv
sim/pe_array_props.sv
sim/tb_pe_array.sv

//--- sim/pe_array_props.sv
// Bound checks of the PE array: every lane's results against modular arithmetic on past operands
`timescale 1ns/1ps

module pe_array_props (
    input logic                     clk,
    input logic                     rst,
    input pe_pkg::pe_alg_t          alg,
    input pe_pkg::pe_instr_t        instr,
    input logic [pe_pkg::WIDTH-1:0] data_in  [0:pe_pkg::NUM_LANES-1][0:pe_pkg::IN_NUM-1],
    input logic [pe_pkg::WIDTH-1:0] data_out [0:pe_pkg::NUM_LANES-1][0:pe_pkg::OUT_NUM-1]
);

    int unsigned fail_count = 0;   // Watched by the testbench top

    // in_hist[k] holds the operands sampled k edges ago
    logic [pe_pkg::WIDTH-1:0] in_hist [1:pe_pkg::LAT_BFLY]
                                      [0:pe_pkg::NUM_LANES-1][0:pe_pkg::IN_NUM-1];
    pe_pkg::pe_instr_t        prev_instr;
    pe_pkg::pe_alg_t          prev_alg;
    logic                     prev_rst;
    int                       hold_cycles;   // Edges out of reset under the same instr and alg
    logic [pe_pkg::WIDTH-1:0] q;

    function automatic logic [pe_pkg::WIDTH-1:0] add_mod(
        input logic [pe_pkg::WIDTH-1:0] a, b, m);
        return pe_pkg::WIDTH'((64'(a) + 64'(b)) % 64'(m));
    endfunction

    function automatic logic [pe_pkg::WIDTH-1:0] sub_mod(
        input logic [pe_pkg::WIDTH-1:0] a, b, m);
        return pe_pkg::WIDTH'((64'(a) + 64'(m) - 64'(b)) % 64'(m));
    endfunction

    function automatic logic [pe_pkg::WIDTH-1:0] mul_mod(
        input logic [pe_pkg::WIDTH-1:0] a, b, m);
        return pe_pkg::WIDTH'((64'(a) * 64'(b)) % 64'(m));
    endfunction

    always_comb begin
        case (alg)
            pe_pkg::DSA_44, pe_pkg::DSA_65, pe_pkg::DSA_87: q = 24'd8380417;
            default:                                        q = 24'd3329;
        endcase
    end

    always_ff @(posedge clk) begin
        in_hist[1] <= data_in;
        for (int k = 2; k <= pe_pkg::LAT_BFLY; k++) begin
            in_hist[k] <= in_hist[k-1];
        end
        prev_instr <= instr;
        prev_alg   <= alg;
        prev_rst   <= rst;
        if (rst) begin
            hold_cycles <= 0;
        end else if (instr != prev_instr || alg != prev_alg) begin
            hold_cycles <= 1;
        end else if (hold_cycles < 8) begin
            hold_cycles <= hold_cycles + 1;
        end
    end

    for (genvar g = 0; g < pe_pkg::NUM_LANES; g++) begin : g_lane
        logic [pe_pkg::WIDTH-1:0] exp0;
        logic [pe_pkg::WIDTH-1:0] exp1;
        logic                     armed;
        int                       need;

        always_comb begin
            logic [pe_pkg::WIDTH-1:0] a5;
            logic [pe_pkg::WIDTH-1:0] b5;
            logic [pe_pkg::WIDTH-1:0] c5;
            a5   = in_hist[pe_pkg::LAT_BFLY][g][0];
            b5   = in_hist[pe_pkg::LAT_BFLY][g][1];
            c5   = in_hist[pe_pkg::LAT_BFLY][g][2];
            exp0 = add_mod(in_hist[1][g][0], in_hist[1][g][1], q);   // Also unknown codes
            exp1 = '0;
            need = pe_pkg::LAT_ADDSUB;
            case (instr)
                pe_pkg::MSUB: exp0 = sub_mod(in_hist[1][g][0], in_hist[1][g][1], q);
                pe_pkg::MMUL: begin
                    need = pe_pkg::LAT_MUL;
                    exp0 = mul_mod(in_hist[pe_pkg::LAT_MUL][g][0],
                                   in_hist[pe_pkg::LAT_MUL][g][1], q);
                end
                pe_pkg::NTT: begin
                    need = pe_pkg::LAT_BFLY;
                    exp0 = add_mod(a5, mul_mod(b5, c5, q), q);
                    exp1 = sub_mod(a5, mul_mod(b5, c5, q), q);
                end
                pe_pkg::INTT: begin
                    need = pe_pkg::LAT_BFLY;
                    exp0 = add_mod(a5, b5, q);
                    exp1 = mul_mod(sub_mod(a5, b5, q), c5, q);
                end
                pe_pkg::BYPASS: begin
                    need = 0;
                    exp0 = data_in[g][0];
                end
                default: ;
            endcase
            armed = (need == 0)
                 || (hold_cycles >= need && instr == prev_instr && alg == prev_alg);
        end

        a_reset_zero: assert property (@(posedge clk)
            (rst && prev_rst && instr != pe_pkg::BYPASS)
                |-> (data_out[g][0] == '0 && data_out[g][1] == '0))
        else begin
            fail_count++;
            $error("ERROR data_out[%0d] = %h %h in reset, expected 0", g,
                   $sampled(data_out[g][0]), $sampled(data_out[g][1]));
        end

        a_word0: assert property (@(posedge clk) armed |-> data_out[g][0] == exp0)
        else begin
            fail_count++;
            $error("ERROR data_out[%0d][0] = %h, expected %h (%s)", g,
                   $sampled(data_out[g][0]), $sampled(exp0), instr.name());
        end

        a_word1: assert property (@(posedge clk) armed |-> data_out[g][1] == exp1)
        else begin
            fail_count++;
            $error("ERROR data_out[%0d][1] = %h, expected %h (%s)", g,
                   $sampled(data_out[g][1]), $sampled(exp1), instr.name());
        end
    end

endmodule

bind pe_array pe_array_props i_props (
    .clk      (clk),
    .rst      (rst),
    .alg      (alg),
    .instr    (instr),
    .data_in  (data_in),
    .data_out (data_out)
);

//--- sim/tb_clock.sv
// Free-running testbench clock, starts low and toggles every half period
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule

//--- sim/tb_pe_array.sv
// Testbench top: resets the PE array, runs every instruction under both moduli, reports the result
`timescale 1ns/1ps

module tb_pe_array #(
    parameter int RESET_CYCLES = 10,
    parameter int RUN_CYCLES   = 40,
    parameter int DRIVE_DELAY  = 10,       // ns after the rising edge
    parameter int EDGE_TIMEOUT = 1000,     // ns
    parameter int TIME_LIMIT   = 200000    // ns for the whole run
);

    logic                     clk;
    logic                     rst;
    pe_pkg::pe_alg_t          alg;
    pe_pkg::pe_instr_t        instr;
    logic [pe_pkg::WIDTH-1:0] data_in  [0:pe_pkg::NUM_LANES-1][0:pe_pkg::IN_NUM-1];
    logic [pe_pkg::WIDTH-1:0] data_out [0:pe_pkg::NUM_LANES-1][0:pe_pkg::OUT_NUM-1];

    tb_clock #(.PERIOD_NS(100)) i_clock (
        .clk (clk)
    );

    pe_array i_pe_array (
        .clk      (clk),
        .rst      (rst),
        .alg      (alg),
        .instr    (instr),
        .data_in  (data_in),
        .data_out (data_out)
    );

    task automatic fail_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    function automatic logic [pe_pkg::WIDTH-1:0] modulus_of(input pe_pkg::pe_alg_t a);
        case (a)
            pe_pkg::DSA_44, pe_pkg::DSA_65, pe_pkg::DSA_87: return pe_pkg::Q_DSA;
            default:                                        return pe_pkg::Q_KEM;
        endcase
    endfunction

    // Fresh operands below the current modulus for every lane
    task automatic randomize_operands();
        logic [pe_pkg::WIDTH-1:0] q;
        q = modulus_of(alg);
        for (int l = 0; l < pe_pkg::NUM_LANES; l++) begin
            for (int k = 0; k < pe_pkg::IN_NUM; k++) begin
                data_in[l][k] = pe_pkg::WIDTH'($urandom % q);
            end
        end
    endtask

    task automatic next_edge();
        logic seen;
        seen = 1'b0;
        fork
            begin
                @(posedge clk);
                seen = 1'b1;
            end
            begin
                #(EDGE_TIMEOUT);
            end
        join_any
        disable fork;
        if (!seen) fail_run("no rising clock edge arrived within the timeout");
    endtask

    task automatic drive_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_edge();
            #(DRIVE_DELAY);
            randomize_operands();
        end
    endtask

    // All six instructions in turn under one parameter set
    task automatic run_family(input pe_pkg::pe_alg_t fam);
        alg = fam;
        for (int k = 0; k <= int'(pe_pkg::BYPASS); k++) begin
            instr = pe_pkg::pe_instr_t'(3'(k));
            drive_cycles(RUN_CYCLES);
        end
    endtask

    initial begin
        void'($urandom(74378));
        rst   = 1'b1;
        alg   = pe_pkg::KEM_512;
        instr = pe_pkg::MADD;
        randomize_operands();

        drive_cycles(RESET_CYCLES);
        rst = 1'b0;

        run_family(pe_pkg::KEM_768);
        run_family(pe_pkg::DSA_65);

        // Reset again with the butterfly pipeline full
        instr = pe_pkg::NTT;
        rst   = 1'b1;
        drive_cycles(3);
        rst = 1'b0;
        drive_cycles(RUN_CYCLES);

        if (i_pe_array.i_props.fail_count != 0) begin
            fail_run("an assertion check failed, see the ERROR line above");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    // Stop at the first failed assertion
    always @(negedge clk) begin
        if (i_pe_array.i_props.fail_count != 0) begin
            fail_run("an assertion check failed, see the ERROR line above");
        end
    end

    initial begin
        #(TIME_LIMIT);
        fail_run("the run exceeded its time limit");
    end

endmodule

//--- source/mod_addsub.sv
// Registered modular adder and subtractor of one lane, one cycle from operands to results
`timescale 1ns/1ps

module mod_addsub (
    input logic        clk,
    input logic        rst,
    mod_addsub_if.unit bus
);

    logic [pe_pkg::WIDTH-1:0] q;
    logic [pe_pkg::WIDTH:0]   sum_full;
    logic [pe_pkg::WIDTH:0]   diff_full;
    logic [pe_pkg::WIDTH:0]   sum_red;
    logic [pe_pkg::WIDTH:0]   diff_red;

    assign q = bus.dsa_mode ? pe_pkg::Q_DSA : pe_pkg::Q_KEM;

    // One extra bit keeps the carry and the borrow
    assign sum_full  = {1'b0, bus.add_a} + {1'b0, bus.add_b};
    assign diff_full = {1'b0, bus.sub_a} - {1'b0, bus.sub_b};

    always_comb begin
        if (sum_full >= {1'b0, q}) begin
            sum_red = sum_full - {1'b0, q};
        end else begin
            sum_red = sum_full;
        end

        if (diff_full[pe_pkg::WIDTH]) begin
            diff_red = diff_full + {1'b0, q};   // Wrap negative back into range
        end else begin
            diff_red = diff_full;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.sum  <= '0;
            bus.diff <= '0;
        end else begin
            bus.sum  <= sum_red[pe_pkg::WIDTH-1:0];
            bus.diff <= diff_red[pe_pkg::WIDTH-1:0];
        end
    end

endmodule

//--- source/pe_array.sv
// Top level of the modular-arithmetic PE array; one lane per coefficient slot
`timescale 1ns/1ps

module pe_array (
    input  logic                     clk,
    input  logic                     rst,
    input  pe_pkg::pe_alg_t          alg,
    input  pe_pkg::pe_instr_t        instr,
    input  logic [pe_pkg::WIDTH-1:0] data_in
                                     [0:pe_pkg::NUM_LANES-1][0:pe_pkg::IN_NUM-1],
    output logic [pe_pkg::WIDTH-1:0] data_out
                                     [0:pe_pkg::NUM_LANES-1][0:pe_pkg::OUT_NUM-1]
);

    // All lanes share instr and alg
    for (genvar g = 0; g < pe_pkg::NUM_LANES; g++) begin : g_lane
        pe_lane i_lane (
            .clk       (clk),
            .rst       (rst),
            .alg       (alg),
            .instr     (instr),
            .in_words  (data_in[g]),
            .out_words (data_out[g])
        );
    end

endmodule

//--- source/pe_lane.sv
// One processing element: routes operands to its units per instruction and selects the results
`timescale 1ns/1ps

module pe_lane (
    input  logic                     clk,
    input  logic                     rst,
    input  pe_pkg::pe_alg_t          alg,
    input  pe_pkg::pe_instr_t        instr,
    input  logic [pe_pkg::WIDTH-1:0] in_words [0:pe_pkg::IN_NUM-1],
    output logic [pe_pkg::WIDTH-1:0] out_words [0:pe_pkg::OUT_NUM-1]
);

    logic dsa_mode;

    // Operand 0 waits for the NTT product, operand 2 for the INTT difference
    logic [pe_pkg::WIDTH-1:0] op0_pipe [0:pe_pkg::LAT_MUL-1];
    logic [pe_pkg::WIDTH-1:0] op2_pipe [0:pe_pkg::LAT_ADDSUB-1];
    logic [pe_pkg::WIDTH-1:0] sum_pipe [0:pe_pkg::LAT_MUL-1];   // INTT sum meets the product

    mod_addsub_if #(.W(pe_pkg::WIDTH)) addsub_bus ();
    mod_mul_if    #(.W(pe_pkg::WIDTH)) mul_bus ();

    assign dsa_mode = (alg == pe_pkg::DSA_44) || (alg == pe_pkg::DSA_65)
                   || (alg == pe_pkg::DSA_87);

    assign addsub_bus.dsa_mode = dsa_mode;
    assign mul_bus.dsa_mode    = dsa_mode;

    mod_addsub i_addsub (
        .clk (clk),
        .rst (rst),
        .bus (addsub_bus.unit)
    );

    mod_mul i_mul (
        .clk (clk),
        .rst (rst),
        .bus (mul_bus.unit)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pe_pkg::LAT_MUL; i++) begin
                op0_pipe[i] <= '0;
                sum_pipe[i] <= '0;
            end
            for (int i = 0; i < pe_pkg::LAT_ADDSUB; i++) begin
                op2_pipe[i] <= '0;
            end
        end else begin
            op0_pipe[0] <= in_words[0];
            sum_pipe[0] <= addsub_bus.sum;
            for (int i = 1; i < pe_pkg::LAT_MUL; i++) begin
                op0_pipe[i] <= op0_pipe[i-1];
                sum_pipe[i] <= sum_pipe[i-1];
            end
            op2_pipe[0] <= in_words[2];
            for (int i = 1; i < pe_pkg::LAT_ADDSUB; i++) begin
                op2_pipe[i] <= op2_pipe[i-1];
            end
        end
    end

    // Operand routing
    always_comb begin
        addsub_bus.add_a = in_words[0];
        addsub_bus.add_b = in_words[1];
        addsub_bus.sub_a = in_words[0];
        addsub_bus.sub_b = in_words[1];
        mul_bus.mul_a    = in_words[0];
        mul_bus.mul_b    = in_words[1];
        case (instr)
            pe_pkg::NTT: begin
                mul_bus.mul_a    = in_words[1];
                mul_bus.mul_b    = in_words[2];
                addsub_bus.add_a = op0_pipe[pe_pkg::LAT_MUL-1];
                addsub_bus.add_b = mul_bus.prod;
                addsub_bus.sub_a = op0_pipe[pe_pkg::LAT_MUL-1];
                addsub_bus.sub_b = mul_bus.prod;
            end
            pe_pkg::INTT: begin
                mul_bus.mul_a = addsub_bus.diff;   // (a-b) times twiddle
                mul_bus.mul_b = op2_pipe[pe_pkg::LAT_ADDSUB-1];
            end
            default: ;
        endcase
    end

    // Result select
    always_comb begin
        out_words[0] = addsub_bus.sum;
        out_words[1] = '0;
        case (instr)
            pe_pkg::MSUB:   out_words[0] = addsub_bus.diff;
            pe_pkg::MMUL:   out_words[0] = mul_bus.prod;
            pe_pkg::NTT:    out_words[1] = addsub_bus.diff;
            pe_pkg::INTT: begin
                out_words[0] = sum_pipe[pe_pkg::LAT_MUL-1];
                out_words[1] = mul_bus.prod;
            end
            pe_pkg::BYPASS: out_words[0] = in_words[0];   // Combinational path
            default: ;
        endcase
    end

endmodule
